// File: design/can_card_pkg.sv
package can_card_pkg;

	localparam int PORT_NUM = 4;
	localparam int PORT_W = $clog2(PORT_NUM);
	localparam int DATA_W = 16;
	localparam int BIT_CYCLES = 8;
	localparam int FRAME_BITS = DATA_W + 2; // Start, data, end
	localparam int TICK_W = $clog2(BIT_CYCLES);
	localparam int BITCNT_W = $clog2(FRAME_BITS);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(BIT_CYCLES - 1);
	localparam logic [BITCNT_W-1:0] LAST_BIT = BITCNT_W'(FRAME_BITS - 1);
	localparam int RST_HOLD = 16;
	localparam int RST_CNT_W = $clog2(RST_HOLD);
	localparam int TEC_W = 8;
	localparam int TEC_ERR_STEP = 8;
	localparam int BUS_OFF_LIMIT = 32;

	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_STATUS = 2'd1;
	localparam logic [1:0] REG_TXDATA = 2'd2;
	localparam logic [1:0] REG_RXDATA = 2'd3;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [31:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} axil_r_t;

	typedef struct packed {
		logic write;
		logic [1:0] offset;
		logic [31:0] wdata;
	} reg_req_t;

endpackage

// File: design/reset_sync.sv
`timescale 1ns/1ps

module reset_sync import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,
	output logic rstn_sync_o
);

	logic [RST_CNT_W-1:0] hold_q;

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			hold_q <= '0;
			rstn_sync_o <= 1'b0;
		end else if (hold_q != RST_CNT_W'(RST_HOLD - 1)) begin
			hold_q <= hold_q + 1'b1;
		end else begin
			rstn_sync_o <= 1'b1; // Counter saturated, release
		end
	end

endmodule

// File: design/axil_reg_bridge.sv
`timescale 1ns/1ps

module axil_reg_bridge import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,

	input logic awvalid_i,
	input axil_aw_t aw_i,
	output logic awready_o,

	input logic wvalid_i,
	input axil_w_t w_i,
	output logic wready_o,

	output logic bvalid_o,
	output logic [1:0] bresp_o,
	input logic bready_i,

	input logic arvalid_i,
	input logic [31:0] araddr_i,
	output logic arready_o,

	output logic rvalid_o,
	output axil_r_t r_o,
	input logic rready_i,

	output logic [PORT_NUM-1:0] sel_o,
	output reg_req_t req_o,
	input logic [PORT_NUM-1:0][31:0] rdata_i
);

	logic pending;
	logic wr_acc;
	logic rd_acc;
	logic [31:0] acc_addr;
	logic mapped;
	logic [PORT_W-1:0] port_idx;

	assign pending = bvalid_o | rvalid_o;
	assign wr_acc = awvalid_i & wvalid_i & ~pending;
	assign rd_acc = arvalid_i & ~pending & ~wr_acc; // Write wins

	assign awready_o = wr_acc;
	assign wready_o = wr_acc;
	assign arready_o = rd_acc;

	assign acc_addr = wr_acc ? aw_i.addr : araddr_i;
	assign mapped = acc_addr < 32'(PORT_NUM * 16);
	assign port_idx = acc_addr[PORT_W+3:4];

	always_comb begin
		sel_o = '0;
		if ((wr_acc || rd_acc) && mapped)
			sel_o[port_idx] = 1'b1;
		req_o.write = wr_acc;
		req_o.offset = acc_addr[3:2];
		// Lanes without strobe are written as zero
		for (int b = 0; b < 4; b++)
			req_o.wdata[8*b +: 8] = w_i.strb[b] ? w_i.data[8*b +: 8] : 8'h00;
	end

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (rd_acc)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_acc)
			bresp_o <= mapped ? RESP_OKAY : RESP_SLVERR;
		if (rd_acc) begin
			r_o.data <= mapped ? rdata_i[port_idx] : 32'h0;
			r_o.resp <= mapped ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// An accepted access holds off the next one until its response leaves
	a_one_in_flight: assert property (@(posedge aclk) disable iff (!rstni)
		(awready_o || arready_o) |=> (bvalid_o || rvalid_o) && !awready_o && !arready_o);

endmodule

// File: design/can_frame_tx.sv
`timescale 1ns/1ps

module can_frame_tx import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,
	input logic start_i,
	input logic [DATA_W-1:0] data_i,
	input logic enable_i,
	input logic rx_i,
	output logic tx_o,
	output logic busy_o,
	output logic done_o,
	output logic err_o
);

	logic [FRAME_BITS-1:0] shift_q;
	logic [TICK_W-1:0] tick_q;
	logic [BITCNT_W-1:0] bit_q;
	logic load;
	logic sample;

	assign load = !busy_o && start_i && enable_i;
	assign sample = busy_o && enable_i && tick_q == LAST_TICK;
	assign tx_o = (busy_o && enable_i) ? shift_q[FRAME_BITS-1] : 1'b1;

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			busy_o <= 1'b0;
			done_o <= 1'b0;
			err_o <= 1'b0;
			tick_q <= '0;
			bit_q <= '0;
		end else begin
			done_o <= 1'b0;
			err_o <= 1'b0;
			if (load) begin
				busy_o <= 1'b1;
				tick_q <= '0;
				bit_q <= '0;
			end else if (busy_o && !enable_i) begin
				busy_o <= 1'b0; // Aborted
			end else if (sample) begin
				tick_q <= '0;
				if (rx_i != tx_o) begin
					busy_o <= 1'b0; // Bit monitor mismatch
					err_o <= 1'b1;
				end else if (bit_q == LAST_BIT) begin
					busy_o <= 1'b0;
					done_o <= 1'b1;
				end else begin
					bit_q <= bit_q + 1'b1;
				end
			end else if (busy_o) begin
				tick_q <= tick_q + 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (load)
			shift_q <= {1'b0, data_i, 1'b1}; // MSB first
		else if (sample)
			shift_q <= {shift_q[FRAME_BITS-2:0], 1'b1};
	end

endmodule

// File: design/can_frame_rx.sv
`timescale 1ns/1ps

module can_frame_rx import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,
	input logic rx_i,
	output logic valid_o,
	output logic [DATA_W-1:0] data_o
);

	logic rx_prev_q;
	logic active_q;
	logic [TICK_W-1:0] tick_q;
	logic [BITCNT_W-1:0] bit_q;
	logic [DATA_W-1:0] shift_q;
	logic sample;

	assign sample = active_q && tick_q == LAST_TICK;
	assign data_o = shift_q;

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			rx_prev_q <= 1'b1;
			active_q <= 1'b0;
			tick_q <= '0;
			bit_q <= '0;
			valid_o <= 1'b0;
		end else begin
			rx_prev_q <= rx_i;
			valid_o <= 1'b0;
			if (!active_q) begin
				if (rx_prev_q && !rx_i) begin
					active_q <= 1'b1;
					tick_q <= TICK_W'(1); // Edge cycle is tick 0
					bit_q <= '0;
				end
			end else if (sample) begin
				tick_q <= '0;
				if (bit_q == '0 && rx_i) begin
					active_q <= 1'b0; // Glitch, no start bit
				end else if (bit_q == LAST_BIT) begin
					active_q <= 1'b0;
					valid_o <= rx_i; // Dominant end bit drops the frame
				end else begin
					bit_q <= bit_q + 1'b1;
				end
			end else begin
				tick_q <= tick_q + 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (sample && bit_q != '0 && bit_q != LAST_BIT)
			shift_q <= {shift_q[DATA_W-2:0], rx_i};
	end

endmodule

// File: design/can_port.sv
`timescale 1ns/1ps

module can_port import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,
	input logic sel_i,
	input reg_req_t req_i,
	output logic [31:0] rdata_o,
	input logic rx_i,
	output logic tx_o,
	output logic bus_off_o,
	output logic irq_o
);

	logic [1:0] ctrl_q; // Tx irq enable, rx irq enable
	logic rx_full_q;
	logic tx_done_q;
	logic [DATA_W-1:0] rx_buf_q;
	logic [TEC_W-1:0] tec_q;
	logic ctrl_wr;
	logic status_wr;
	logic tx_start;
	logic rx_rd;
	logic tx_busy;
	logic tx_done;
	logic tx_err;
	logic rx_valid;
	logic [DATA_W-1:0] rx_data;

	assign ctrl_wr = sel_i && req_i.write && req_i.offset == REG_CTRL;
	assign status_wr = sel_i && req_i.write && req_i.offset == REG_STATUS;
	assign tx_start = sel_i && req_i.write && req_i.offset == REG_TXDATA && !tx_busy && !bus_off_o;
	assign rx_rd = sel_i && !req_i.write && req_i.offset == REG_RXDATA;
	assign bus_off_o = tec_q >= TEC_W'(BUS_OFF_LIMIT);
	assign irq_o = (rx_full_q & ctrl_q[0]) | (tx_done_q & ctrl_q[1]);

	always_comb begin
		rdata_o = '0;
		case (req_i.offset)
			REG_CTRL: rdata_o[1:0] = ctrl_q;
			REG_STATUS: rdata_o = {16'h0, tec_q, 4'h0, bus_off_o, tx_done_q, rx_full_q, tx_busy};
			REG_RXDATA: rdata_o[DATA_W-1:0] = rx_buf_q;
			default: rdata_o = '0; // TXDATA is write only
		endcase
	end

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			ctrl_q <= '0;
			rx_full_q <= 1'b0;
			tx_done_q <= 1'b0;
			tec_q <= '0;
		end else begin
			if (ctrl_wr)
				ctrl_q <= req_i.wdata[1:0];
			if (rx_valid)
				rx_full_q <= 1'b1;
			else if (rx_rd)
				rx_full_q <= 1'b0;
			if (tx_done)
				tx_done_q <= 1'b1;
			else if (status_wr && req_i.wdata[2])
				tx_done_q <= 1'b0;
			if (ctrl_wr && req_i.wdata[2])
				tec_q <= '0;
			else if (tx_err)
				tec_q <= tec_q + TEC_W'(TEC_ERR_STEP);
			else if (tx_done && tec_q != '0)
				tec_q <= tec_q - 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (rx_valid)
			rx_buf_q <= rx_data; // Newer frame overwrites
	end

	can_frame_tx can_frame_tx_i (
		.aclk(aclk),
		.rstni(rstni),
		.start_i(tx_start),
		.data_i(req_i.wdata[DATA_W-1:0]),
		.enable_i(!bus_off_o),
		.rx_i(rx_i),
		.tx_o(tx_o),
		.busy_o(tx_busy),
		.done_o(tx_done),
		.err_o(tx_err)
	);

	can_frame_rx can_frame_rx_i (
		.aclk(aclk),
		.rstni(rstni),
		.rx_i(rx_i),
		.valid_o(rx_valid),
		.data_o(rx_data)
	);

	a_off_recessive: assert property (@(posedge aclk) disable iff (!rstni)
		bus_off_o |-> tx_o);

endmodule

// File: design/can_card_top.sv
`timescale 1ns/1ps

module can_card_top import can_card_pkg::*; (
	input logic aclk,
	input logic rstni,

	input logic awvalid_i,
	input axil_aw_t aw_i,
	output logic awready_o,
	input logic wvalid_i,
	input axil_w_t w_i,
	output logic wready_o,
	output logic bvalid_o,
	output logic [1:0] bresp_o,
	input logic bready_i,
	input logic arvalid_i,
	input logic [31:0] araddr_i,
	output logic arready_o,
	output logic rvalid_o,
	output axil_r_t r_o,
	input logic rready_i,

	input logic [PORT_NUM-1:0] rx_i,
	output logic [PORT_NUM-1:0] tx_o,
	output logic [PORT_NUM-1:0] bus_off_o,
	output logic intr_o
);

	logic rstn_sync;
	logic [PORT_NUM-1:0] sel;
	reg_req_t req;
	logic [PORT_NUM-1:0][31:0] rdata;
	logic [PORT_NUM-1:0] irq;

	reset_sync reset_sync_i (
		.aclk(aclk),
		.rstni(rstni),
		.rstn_sync_o(rstn_sync)
	);

	axil_reg_bridge axil_reg_bridge_i (
		.aclk(aclk),
		.rstni(rstn_sync),
		.awvalid_i(awvalid_i),
		.aw_i(aw_i),
		.awready_o(awready_o),
		.wvalid_i(wvalid_i),
		.w_i(w_i),
		.wready_o(wready_o),
		.bvalid_o(bvalid_o),
		.bresp_o(bresp_o),
		.bready_i(bready_i),
		.arvalid_i(arvalid_i),
		.araddr_i(araddr_i),
		.arready_o(arready_o),
		.rvalid_o(rvalid_o),
		.r_o(r_o),
		.rready_i(rready_i),
		.sel_o(sel),
		.req_o(req),
		.rdata_i(rdata)
	);

	generate
		for (genvar i = 0; i < PORT_NUM; i++) begin : g_port
			can_port can_port_i (
				.aclk(aclk),
				.rstni(rstn_sync),
				.sel_i(sel[i]),
				.req_i(req),
				.rdata_o(rdata[i]),
				.rx_i(rx_i[i]),
				.tx_o(tx_o[i]),
				.bus_off_o(bus_off_o[i]),
				.irq_o(irq[i])
			);
		end
	endgenerate

	assign intr_o = |irq; // One line for the host

endmodule

// File: test/tb_can_card.sv
`timescale 1ns/1ps

module tb_can_card import can_card_pkg::*;;

	localparam int TIMEOUT_CYCLES = (12 * 150 + 200) * 10; // Twelve frames plus margin times ten
	localparam int POLL_MAX = 200;

	logic aclk;
	logic rstni;
	logic awvalid;
	axil_aw_t aw;
	logic awready;
	logic wvalid;
	axil_w_t w;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic bready;
	logic arvalid;
	logic [31:0] araddr;
	logic arready;
	logic rvalid;
	axil_r_t r;
	logic rready;
	logic [PORT_NUM-1:0] rx_line;
	logic [PORT_NUM-1:0] tx_line;
	logic [PORT_NUM-1:0] bus_off;
	logic [PORT_NUM-1:0] fault;
	logic intr;
	int errors;
	int cycles;

	assign rx_line = tx_line & ~fault; // Faulted line held dominant

	can_card_top can_card_top_i (
		.aclk(aclk),
		.rstni(rstni),
		.awvalid_i(awvalid),
		.aw_i(aw),
		.awready_o(awready),
		.wvalid_i(wvalid),
		.w_i(w),
		.wready_o(wready),
		.bvalid_o(bvalid),
		.bresp_o(bresp),
		.bready_i(bready),
		.arvalid_i(arvalid),
		.araddr_i(araddr),
		.arready_o(arready),
		.rvalid_o(rvalid),
		.r_o(r),
		.rready_i(rready),
		.rx_i(rx_line),
		.tx_o(tx_line),
		.bus_off_o(bus_off),
		.intr_o(intr)
	);

	initial begin
		aclk = 1'b0;
		forever #20 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] reg_addr(input int port, input logic [1:0] offset);
		return 32'(port * 16) + {28'h0, offset, 2'b00};
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic full,
		input logic done, input logic off, input logic [7:0] tec);
		logic [31:0] st;
		st = '0;
		st[0] = busy;
		st[1] = full;
		st[2] = done;
		st[3] = off;
		st[15:8] = tec;
		return st;
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge aclk);
		awvalid <= 1'b1;
		aw.addr <= addr;
		wvalid <= 1'b1;
		w.data <= data;
		w.strb <= 4'hf;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!(awready && wready) && n < POLL_MAX);
		if (!(awready && wready)) begin
			$display("Write to 0x%0h was never accepted", addr);
			errors++;
		end
		@(posedge aclk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!bvalid && n < POLL_MAX);
		if (!bvalid) begin
			$display("Write to 0x%0h got no response", addr);
			errors++;
		end
		resp = bresp;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge aclk);
		arvalid <= 1'b1;
		araddr <= addr;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!arready && n < POLL_MAX);
		if (!arready) begin
			$display("Read from 0x%0h was never accepted", addr);
			errors++;
		end
		@(posedge aclk);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!rvalid && n < POLL_MAX);
		if (!rvalid) begin
			$display("Read from 0x%0h got no response", addr);
			errors++;
		end
		data = r.data;
		resp = r.resp;
	endtask

	// Reads STATUS until bit idx reaches level
	task automatic poll_status(input int port, input int idx, input logic level,
		output logic [31:0] st);
		logic [1:0] resp;
		int n;
		n = 0;
		do begin
			axi_read(reg_addr(port, REG_STATUS), st, resp);
			n++;
		end while (st[idx] !== level && n < POLL_MAX);
		if (st[idx] !== level) begin
			$display("Status bit %0d of port %0d never reached %0b", idx, port, level);
			errors++;
		end
	endtask

	task automatic reset_state();
		logic [31:0] st;
		logic [1:0] resp;
		@(negedge aclk);
		check("tx_o", 32'(tx_line), 32'hf);
		check("bus_off_o", 32'(bus_off), 32'h0);
		check("intr_o", 32'(intr), 32'h0);
		check("ready_valid", {28'h0, awready, wready, arready, bvalid | rvalid}, 32'h0);
		for (int p = 0; p < PORT_NUM; p++) begin
			axi_read(reg_addr(p, REG_STATUS), st, resp);
			check($sformatf("status[%0d]", p), st, 32'h0);
		end
	endtask

	task automatic loopback(input int port);
		logic [31:0] data;
		logic [31:0] st;
		logic [31:0] rd;
		logic [1:0] resp;
		data = 32'($urandom) & 32'h0000_ffff;
		axi_write(reg_addr(port, REG_CTRL), 32'h3, resp); // Both interrupts on
		axi_write(reg_addr(port, REG_TXDATA), data, resp);
		poll_status(port, 2, 1'b1, st);
		check($sformatf("status[%0d]", port), st, status_word(1'b0, 1'b1, 1'b1, 1'b0, 8'h0));
		@(negedge aclk);
		check("intr_o", 32'(intr), 32'h1);
		axi_read(reg_addr(port, REG_RXDATA), rd, resp);
		check($sformatf("rxdata[%0d]", port), rd, data);
		axi_write(reg_addr(port, REG_STATUS), 32'h4, resp);
		axi_read(reg_addr(port, REG_STATUS), st, resp);
		check($sformatf("status[%0d]", port), st, 32'h0);
	endtask

	task automatic irq_masking();
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] st;
		logic [31:0] rd;
		logic [1:0] resp;
		d0 = 32'($urandom) & 32'h0000_ffff;
		d1 = 32'($urandom) & 32'h0000_ffff;
		axi_write(reg_addr(1, REG_CTRL), 32'h0, resp);
		axi_write(reg_addr(1, REG_TXDATA), d0, resp);
		poll_status(1, 2, 1'b1, st);
		@(negedge aclk);
		check("intr_o", 32'(intr), 32'h0); // Flags set with enables off
		check("status[1]", st, status_word(1'b0, 1'b1, 1'b1, 1'b0, 8'h0));
		axi_read(reg_addr(1, REG_RXDATA), rd, resp);
		check("rxdata[1]", rd, d0);
		axi_write(reg_addr(1, REG_STATUS), 32'h4, resp);
		axi_read(reg_addr(1, REG_STATUS), st, resp);
		check("status[1]", st, 32'h0);
		axi_write(reg_addr(1, REG_TXDATA), d1, resp);
		axi_write(reg_addr(1, REG_TXDATA), d1 ^ 32'hffff, resp); // Lands while busy
		poll_status(1, 2, 1'b1, st);
		axi_read(reg_addr(1, REG_RXDATA), rd, resp);
		check("rxdata[1]", rd, d1);
		axi_write(reg_addr(1, REG_STATUS), 32'h4, resp);
	endtask

	task automatic bus_off_recovery();
		logic [31:0] st;
		logic [1:0] resp;
		@(posedge aclk);
		fault[2] <= 1'b1;
		for (int k = 1; k <= 4; k++) begin
			axi_write(reg_addr(2, REG_TXDATA), 32'hffff, resp);
			poll_status(2, 0, 1'b0, st);
			check("tec[2]", 32'(st[15:8]), 32'(k * TEC_ERR_STEP));
		end
		@(negedge aclk);
		check("bus_off_o", 32'(bus_off), 32'h4);
		check("tx_o", 32'(tx_line), 32'hf);
		axi_write(reg_addr(2, REG_TXDATA), 32'hffff, resp);
		axi_read(reg_addr(2, REG_STATUS), st, resp);
		check("status[2]", st, status_word(1'b0, 1'b0, 1'b0, 1'b1, 8'(4 * TEC_ERR_STEP)));
		check("tx_o", 32'(tx_line), 32'hf);
		loopback(0);
		loopback(1);
		loopback(3);
		@(posedge aclk);
		fault[2] <= 1'b0;
		axi_write(reg_addr(2, REG_CTRL), 32'h4, resp);
		axi_read(reg_addr(2, REG_STATUS), st, resp);
		check("status[2]", st, 32'h0);
		@(negedge aclk);
		check("bus_off_o", 32'(bus_off), 32'h0);
		loopback(2);
	endtask

	task automatic address_errors();
		logic [31:0] rd;
		logic [1:0] resp;
		for (int p = 0; p < PORT_NUM; p++) begin
			axi_write(reg_addr(p, REG_CTRL), 32'h3, resp);
			check("bresp", 32'(resp), 32'(RESP_OKAY));
		end
		axi_write(32'h40, 32'h4, resp); // Would clear CTRL if it aliased port 0
		check("bresp", 32'(resp), 32'(RESP_SLVERR));
		axi_read(32'h40, rd, resp);
		check("rresp", 32'(resp), 32'(RESP_SLVERR));
		check("rdata", rd, 32'h0);
		for (int p = 0; p < PORT_NUM; p++) begin
			axi_read(reg_addr(p, REG_CTRL), rd, resp);
			check($sformatf("ctrl[%0d]", p), rd, 32'h3);
			check("rresp", 32'(resp), 32'(RESP_OKAY));
			axi_read(reg_addr(p, REG_STATUS), rd, resp);
			check($sformatf("status[%0d]", p), rd, 32'h0);
		end
	endtask

	initial begin
		void'($urandom(61));
		rstni <= 1'b0;
		awvalid <= 1'b0;
		aw <= '0;
		wvalid <= 1'b0;
		w <= '0;
		bready <= 1'b1;
		arvalid <= 1'b0;
		araddr <= '0;
		rready <= 1'b1;
		fault <= '0;
		repeat (5) @(posedge aclk);
		rstni <= 1'b1;
		repeat (RST_HOLD + 2) @(posedge aclk);
		reset_state();
		for (int p = 0; p < PORT_NUM; p++)
			loopback(p);
		irq_masking();
		bus_off_recovery();
		address_errors();
		$display("Run complete with %0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: src.f
design/can_card_pkg.sv
design/reset_sync.sv
design/axil_reg_bridge.sv
design/can_frame_tx.sv
design/can_frame_rx.sv
design/can_port.sv
design/can_card_top.sv
test/tb_can_card.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_can_card
FILELIST = src.f

OBJ_DIR  = obj_dir
EXE      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
